//--- zmips.f
hw/zmips_pkg.sv
hw/zmips_pipe_if.sv
hw/zmips_fetch.sv
hw/zmips_decode.sv
hw/zmips_regfile.sv
hw/zmips_execute.sv
hw/zmips_memwb.sv
hw/zmips.sv
test/tb_clock.sv
test/tb_mem.sv
test/zmips_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the zmips testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f zmips.f --top-module zmips_tb \
        --Mdir obj_dir -o zmips_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/zmips_sim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation run failed"
    exit 1
fi

cat sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
    exit 0
fi
exit 1

//--- test/zmips_tb.sv
// zmips testbench, assembles directed programs, runs them and checks the data RAM
module zmips_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import zmips_pkg::*;

    localparam int n_tests   = 5;
    localparam int run_max   = 600;  // Cycles from reset release to the halt loop
    localparam int load_max  = 512;  // One cycle per program word
    localparam int test_cyc  = load_max + run_max + 40;
    localparam int wd_cycles = n_tests * test_cyc + 16;

    logic        clk;
    logic        rst;
    logic        restart;
    logic [31:0] i_addr;
    logic [31:0] i_data;
    logic [31:0] d_addr;
    logic [31:0] d_wdata;
    logic [31:0] d_rdata;
    logic        d_rd;
    logic        d_wr;
    logic        prog_wr;
    logic [8:0]  prog_addr;
    logic [31:0] prog_data;
    logic        ram_clr;

    instr_t      prog[$];   // Program being assembled
    logic [31:0] exp_q[$];  // Expected words from RAM index 0 up
    logic [31:0] halt_addr;
    logic [31:0] rng;
    int          errors = 0;
    int          checks = 0;
    int          tests  = 0;

    tb_clock clkgen (.clk(clk), .restart(restart), .rst(rst));

    tb_mem mem (
        .clk(clk), .i_addr(i_addr), .i_data(i_data), .d_addr(d_addr),
        .d_wdata(d_wdata), .d_rdata(d_rdata), .d_rd(d_rd), .d_wr(d_wr),
        .prog_wr(prog_wr), .prog_addr(prog_addr), .prog_data(prog_data),
        .ram_clr(ram_clr)
    );

    zmips #(.reset_pc(32'd0)) UUT (
        .clk(clk), .rst(rst), .i_addr(i_addr), .i_data(i_data), .d_addr(d_addr),
        .d_wdata(d_wdata), .d_rdata(d_rdata), .d_rd(d_rd), .d_wr(d_wr)
    );

    // Instruction encoders
    function automatic instr_t enc_r(logic [5:0] op, int rs, int rt, int rd, int sh,
                                     logic [5:0] funct);
        instr_t w;
        w         = '0;
        w.r.op    = op;
        w.r.rs    = 5'(rs);
        w.r.rt    = 5'(rt);
        w.r.rd    = 5'(rd);
        w.r.shamt = 5'(sh);
        w.r.funct = funct;
        return w;
    endfunction

    function automatic instr_t enc_li(int v);
        instr_t w;
        w       = '0;
        w.i.fmt = fmt_li;
        w.i.imm = 26'(v);
        return w;
    endfunction

    function automatic instr_t enc_br(int sense, int cc, int off);
        instr_t w;
        w         = '0;
        w.i.fmt   = fmt_br;
        w.i.sense = sense != 0;
        w.i.cc    = 2'(cc);
        w.i.imm   = 26'(off); // In words, relative to branch + 4
        return w;
    endfunction

    // Operation index 0..7 to funct select: and or xor add sub sll srl sra
    function automatic logic [2:0] sel_of(int k);
        case (k)
            0:       return alu_and;
            1:       return alu_or;
            2:       return alu_xor;
            3:       return alu_add;
            4:       return alu_sub;
            5:       return alu_sll;
            6:       return alu_srl;
            default: return alu_sra;
        endcase
    endfunction

    // Reference results straight from the instruction rules
    function automatic logic [31:0] model(int k, logic [31:0] a, logic [31:0] b, int sh);
        case (k)
            0:       return a & b;
            1:       return a | b;
            2:       return a ^ b;
            3:       return a + b;
            4:       return a - b;
            5:       return a << sh;
            6:       return a >> sh;
            default: return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
        endcase
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic emit(instr_t w);
        prog.push_back(w);
    endtask

    // ALU op, shift op, or shifts take rs as the operand
    task automatic emit_op(int k, int rd, int rs, int rt, int sh, logic [2:0] flags);
        if (k >= 5)
            emit(enc_r(6'b000101, rs, 0, rd, sh, {sel_of(k), 3'b000}));
        else
            emit(enc_r(6'b000100, rs, rt, rd, 0, {sel_of(k), flags}));
    endtask

    // Full 32-bit constant through r0
    task automatic set_reg(int r, logic [31:0] v);
        emit(enc_li(int'({16'h0, v[31:16]})));
        emit_op(1, r, 0, 0, 0, 3'b000);
        emit_op(5, r, r, 0, 16, 3'b000);
        emit(enc_li(int'({16'h0, v[15:0]})));
        emit_op(1, r, r, 0, 0, 3'b000);
    endtask

    // Store at r29 then step r29 by r28 (4), flags untouched
    task automatic store_next(int r);
        emit(enc_r(6'b001001, 29, r, 0, 0, {alu_pass, 3'b000}));
        emit_op(3, 29, 29, 28, 0, 3'b000);
    endtask

    task automatic mark(int k);
        emit(enc_li(k));
        store_next(0);
    endtask

    task automatic begin_prog();
        prog.delete();
        exp_q.delete();
        set_reg(28, 32'd4);
        set_reg(29, 32'd0);
    endtask

    task automatic load_prog();
        for (int i = 0; i < prog.size(); i++)
        begin
            @(posedge clk);
            #1;
            prog_wr   = 1'b1;
            prog_addr = 9'(i);
            prog_data = prog[i];
        end
        @(posedge clk);
        #1 prog_wr = 1'b0;
    endtask

    // Restart reset, clear RAM inside it, wait for release
    task automatic reset_core();
        @(posedge clk);
        #1 restart = 1'b1;
        @(posedge clk);
        #1 restart = 1'b0;
        @(posedge clk);
        #1 ram_clr = 1'b1;
        @(posedge clk);
        #1 ram_clr = 1'b0;
        while (rst)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_word(string name, int idx, logic [31:0] exp);
        logic [31:0] got;
        got = mem.ram[8'(idx)];
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH t=%0t %s RAM word %0d got %h expected %h",
                     $time, name, idx, got, exp);
        end
    endtask

    // Halt loop, load, run, compare
    task automatic run_prog(string name, int extra_idx, logic [31:0] extra_val);
        int  e0;
        int  n;
        bit  found;
        e0    = errors;
        found = 0;
        halt_addr = 32'(prog.size() * 4);
        emit(enc_br(0, cc_always, -1)); // Branch to self
        emit(enc_r(6'b0, 0, 0, 0, 0, 6'b0));
        load_prog();
        reset_core();
        for (n = 0; n < run_max && !found; n++)
        begin
            @(posedge clk);
            #1;
            if (i_addr == halt_addr)
                found = 1;
        end
        if (!found)
        begin
            errors++;
            $display("%s: program never reached its halt loop at t=%0t", name, $time);
        end
        repeat (8) @(posedge clk); // Drain stores
        #1;
        for (int i = 0; i < exp_q.size(); i++)
            check_word(name, i, exp_q[i]);
        check_word(name, exp_q.size(), 32'h0); // Nothing stored past the list
        if (extra_idx >= 0)
            check_word(name, extra_idx, extra_val);
        tests++;
        $display("test %0d %s: %s, %0d errors", tests, name,
                 (errors == e0) ? "ok" : "failed", errors - e0);
    endtask

    task automatic test_alu_fwd();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] e3;
        logic [31:0] e4;
        logic [31:0] e5;
        logic [31:0] e6;
        a = 32'h0f0f_1234;
        b = 32'h00ff_5678;
        begin_prog();
        set_reg(1, a);
        set_reg(2, b);
        emit_op(3, 3, 1, 2, 0, 3'b000); // r2 at distance 1
        emit_op(0, 4, 2, 1, 0, 3'b000);
        emit_op(1, 5, 3, 4, 0, 3'b000); // r3 at distance 2
        emit_op(2, 6, 3, 5, 0, 3'b000); // r3 at distance 3
        emit_op(4, 7, 6, 4, 0, 3'b000);
        emit_op(4, 8, 2, 1, 0, 3'b000);
        for (int r = 3; r <= 8; r++)
            store_next(r);
        e3 = model(3, a, b, 0);
        e4 = model(0, b, a, 0);
        e5 = model(1, e3, e4, 0);
        e6 = model(2, e3, e5, 0);
        exp_q = '{e3, e4, e5, e6, model(4, e6, e4, 0), model(4, b, a, 0)};
        run_prog("alu_forwarding", -1, 32'h0);
    endtask

    task automatic test_shifts();
        logic [31:0] vals[2];
        int          amts[4];
        vals = '{32'h1234_5678, 32'h8765_4321};
        amts = '{0, 1, 4, 31};
        begin_prog();
        foreach (vals[v])
        begin
            set_reg(1, vals[v]);
            foreach (amts[s])
            begin
                for (int k = 5; k <= 7; k++)
                begin
                    emit_op(k, 2, 1, 0, amts[s], 3'b000);
                    store_next(2);
                    exp_q.push_back(model(k, vals[v], 32'h0, amts[s]));
                end
            end
        end
        run_prog("shifts", -1, 32'h0);
    endtask

    task automatic test_load_store();
        logic [31:0] v;
        v = 32'h1234_abcd;
        begin_prog();
        set_reg(1, v);
        set_reg(2, 32'h200);
        emit(enc_r(6'b001001, 2, 1, 0, 0, {alu_pass, 3'b000})); // Store r1 at 0x200
        emit(enc_r(6'b001101, 2, 0, 3, 0, {alu_pass, 3'b000})); // Load r3
        emit_op(3, 4, 3, 3, 0, 3'b000);                         // Load-use stall
        store_next(4);
        emit(enc_r(6'b001101, 2, 0, 5, 0, {alu_pass, 3'b000}));
        store_next(5);                                          // Store of a fresh load
        emit(enc_r(6'b001101, 2, 0, 6, 0, {alu_pass, 3'b000}));
        emit(enc_r(6'b0, 0, 0, 0, 0, 6'b0));
        emit_op(2, 7, 6, 2, 0, 3'b000);                         // Load at distance 2
        store_next(7);
        exp_q = '{v + v, v, v ^ 32'h200};
        run_prog("load_store", 128, v);
    endtask

    // One branch with a fall-through marker and a join marker
    task automatic branch_check(int cc, int sense, bit taken, int tag);
        int b;
        b = prog.size();
        emit(enc_r(6'b0, 0, 0, 0, 0, 6'b0));
        emit_op(3, 29, 29, 28, 0, 3'b000); // Slot dropped behind every branch
        mark(16'h100 + tag);
        prog[b] = enc_br(sense, cc, prog.size() - b - 1);
        mark(16'h200 + tag);
        if (!taken)
            exp_q.push_back(32'(16'h100 + tag));
        exp_q.push_back(32'(16'h200 + tag));
    endtask

    task automatic test_branches();
        logic [31:0] pa[4];
        logic [31:0] pb[4];
        logic [2:0]  fl;
        pa = '{32'd5, 32'd9, 32'd3, 32'hffff_fff8};
        pb = '{32'd5, 32'd3, 32'd9, 32'd2};
        begin_prog();
        foreach (pa[p])
        begin
            set_reg(1, pa[p]);
            set_reg(2, pb[p]);
            emit(enc_r(6'b0, 1, 2, 0, 0, {alu_sub, 3'b111})); // Compare
            emit_op(4, 3, 2, 1, 0, 3'b000); // No flag enables, decisions unchanged
            emit_op(2, 3, 1, 1, 0, 3'b000);
            fl[cc_z] = pa[p] == pb[p];
            fl[cc_c] = pa[p] >= pb[p];      // No borrow
            fl[cc_n] = model(4, pa[p], pb[p], 0) >> 31 != 0;
            for (int cc = 0; cc < 3; cc++)
            begin
                for (int s = 0; s < 2; s++)
                    branch_check(cc, s, fl[cc] == (s != 0), p * 8 + cc * 2 + s);
            end
        end
        branch_check(cc_always, 0, 1'b1, 63);
        run_prog("flags_branches", -1, 32'h0);
    endtask

    task automatic test_random();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        int          k;
        int          sh;
        rng = 32'd93;
        begin_prog();
        for (int i = 0; i < 20; i++)
        begin
            rng = xorshift(rng);
            a   = rng;
            rng = xorshift(rng);
            b   = rng;
            rng = xorshift(rng);
            r   = rng;
            k   = int'(r[2:0]);
            sh  = int'(r[7:3]);
            set_reg(1, a);
            set_reg(2, b);
            emit_op(k, 3, 1, 2, sh, 3'b000);
            store_next(3);
            exp_q.push_back(model(k, a, b, sh));
        end
        run_prog("random", -1, 32'h0);
    endtask

    initial
    begin
        restart   = 1'b0;
        prog_wr   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        ram_clr   = 1'b0;
        test_alu_fwd();
        test_shifts();
        test_load_store();
        test_branches();
        test_random();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // Whole-run limit
    initial
    begin
        #(wd_cycles * 10);
        $display("Watchdog expired after %0d cycles, run did not finish", wd_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- test/tb_mem.sv
// Testbench instruction ROM and data RAM, combinational reads and a program load port
module tb_mem (
    input  logic        clk,
    input  logic [31:0] i_addr,
    output logic [31:0] i_data,
    input  logic [31:0] d_addr,
    input  logic [31:0] d_wdata,
    output logic [31:0] d_rdata,
    input  logic        d_rd,
    input  logic        d_wr,
    input  logic        prog_wr,   // Program load, one word per cycle
    input  logic [8:0]  prog_addr,
    input  logic [31:0] prog_data,
    input  logic        ram_clr
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] rom [512]; // Word addressed
    logic [31:0] ram [256];

    initial
    begin
        for (int i = 0; i < 512; i++)
            rom[i] = '0; // Nop
        for (int i = 0; i < 256; i++)
            ram[i] = '0;
    end

    assign i_data  = rom[i_addr[10:2]];
    assign d_rdata = d_rd ? ram[d_addr[9:2]] : '0;

    always @(posedge clk)
    begin
        if (prog_wr)
            rom[prog_addr] <= prog_data;
        if (ram_clr)
        begin
            for (int i = 0; i < 256; i++)
                ram[i] <= '0;
        end
        else if (d_wr)
            ram[d_addr[9:2]] <= d_wdata;
    end

endmodule

//--- test/tb_clock.sv
// Testbench clock source, 10 ns period, with a 16-cycle reset that can be restarted
module tb_clock (
    output logic clk,
    input  logic restart,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int rst_cycles = 16;

    int cnt = 0; // Cycles since reset started

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        if (restart)
            cnt <= 0;
        else if (cnt < rst_cycles)
            cnt <= cnt + 1;
    end

    assign rst = cnt < rst_cycles; // High from time 0 and after each restart

endmodule

//--- hw/zmips.sv
// zmips top level, five-stage pipelined core with external instruction and data ports
module zmips #(
    parameter logic [zmips_pkg::word_w-1:0] reset_pc = '0
) (
    input  logic                         clk,
    input  logic                         rst,
    output logic [zmips_pkg::word_w-1:0] i_addr,
    input  logic [zmips_pkg::word_w-1:0] i_data,
    output logic [zmips_pkg::word_w-1:0] d_addr,
    output logic [zmips_pkg::word_w-1:0] d_wdata,
    input  logic [zmips_pkg::word_w-1:0] d_rdata,
    output logic                         d_rd,
    output logic                         d_wr
);
    import zmips_pkg::*;

    logic [word_w-1:0]     ifid_pc;
    instr_t                ifid_ir;
    logic                  stall;
    logic                  squash;
    logic                  pc_load;
    logic [word_w-1:0]     pc_target;
    logic [2:0]            flags_fwd;
    logic [reg_addr_w-1:0] rs_addr;
    logic [reg_addr_w-1:0] rt_addr;
    logic [word_w-1:0]     rs_val;
    logic [word_w-1:0]     rt_val;
    logic [reg_addr_w-1:0] wb_addr; // Writeback bus
    logic [word_w-1:0]     wb_data;
    logic                  wb_wr;

    id_ex_if  idex ();
    ex_mem_if exmem ();

    zmips_fetch #(.reset_pc(reset_pc)) u_fetch (
        .clk(clk), .rst(rst), .stall(stall), .squash(squash),
        .pc_load(pc_load), .pc_target(pc_target), .i_data(i_data),
        .pc(i_addr), .ifid_pc(ifid_pc), .ifid_ir(ifid_ir)
    );

    zmips_decode u_decode (
        .clk(clk), .rst(rst), .ifid_pc(ifid_pc), .ifid_ir(ifid_ir),
        .flags_fwd(flags_fwd), .rs_val(rs_val), .rt_val(rt_val),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .stall(stall), .squash(squash),
        .pc_load(pc_load), .pc_target(pc_target), .idex(idex), .exmem(exmem)
    );

    zmips_regfile u_regfile (
        .clk(clk), .rs_addr(rs_addr), .rt_addr(rt_addr), .wb_addr(wb_addr),
        .wb_data(wb_data), .wb_wr(wb_wr), .rs_val(rs_val), .rt_val(rt_val)
    );

    zmips_execute u_execute (
        .clk(clk), .rst(rst), .idex(idex), .exmem(exmem), .wb_addr(wb_addr),
        .wb_data(wb_data), .wb_wr(wb_wr), .flags_fwd(flags_fwd)
    );

    zmips_memwb u_memwb (
        .clk(clk), .rst(rst), .exmem(exmem), .d_rdata(d_rdata),
        .d_addr(d_addr), .d_wdata(d_wdata), .d_rd(d_rd), .d_wr(d_wr),
        .wb_addr(wb_addr), .wb_data(wb_data), .wb_wr(wb_wr)
    );

endmodule

//--- hw/zmips_memwb.sv
// zmips memory and writeback stages, data port, MEM/WB register and result select
module zmips_memwb (
    input  logic                             clk,
    input  logic                             rst,
    ex_mem_if.mem                            exmem,
    input  logic [zmips_pkg::word_w-1:0]     d_rdata,
    output logic [zmips_pkg::word_w-1:0]     d_addr,
    output logic [zmips_pkg::word_w-1:0]     d_wdata,
    output logic                             d_rd,
    output logic                             d_wr,
    output logic [zmips_pkg::reg_addr_w-1:0] wb_addr,
    output logic [zmips_pkg::word_w-1:0]     wb_data,
    output logic                             wb_wr
);
    import zmips_pkg::*;

    logic [word_w-1:0] mem_d; // Load data captured in MEM
    logic [word_w-1:0] alu_d;
    logic              ld_q;  // Writeback from memory

    assign d_addr  = exmem.alu_rslt;
    assign d_wdata = exmem.st_data;
    assign d_rd    = exmem.mem_rd;
    assign d_wr    = exmem.mem_wr;

    always_ff @(posedge clk)
    begin
        mem_d   <= d_rdata;
        alu_d   <= exmem.alu_rslt;
        wb_addr <= exmem.wb_reg;
        if (rst)
        begin
            ld_q  <= 1'b0;
            wb_wr <= 1'b0;
        end
        else
        begin
            ld_q  <= exmem.mem_rd;
            wb_wr <= exmem.wr_reg;
        end
    end

    assign wb_data = ld_q ? mem_d : alu_d;

    a_port_excl: assert property (@(posedge clk) disable iff (rst) !(d_rd && d_wr));

endmodule

//--- hw/zmips_execute.sv
// zmips execute stage, operand forwarding, ALU and shifter, flags and EX/MEM register
module zmips_execute (
    input  logic                             clk,
    input  logic                             rst,
    id_ex_if.ex                              idex,
    ex_mem_if.ex                             exmem,
    input  logic [zmips_pkg::reg_addr_w-1:0] wb_addr,
    input  logic [zmips_pkg::word_w-1:0]     wb_data,
    input  logic                             wb_wr,
    output logic [2:0]                       flags_fwd
);
    import zmips_pkg::*;

    logic [word_w-1:0]  fwd_a;
    logic [word_w-1:0]  op_a;
    logic [word_w-1:0]  op_b;
    logic [word_w-1:0]  sum;
    logic [word_w-1:0]  rslt;
    logic               cout;
    logic               carry;   // Adder carry, 0 for logic and shift
    logic               is_sub;
    logic [2:0]         alu_sel;
    logic [shamt_w-1:0] shamt;
    logic [2:0]         flag_q;  // Z, C, N by cc index
    logic [2:0]         flag_en;
    logic [2:0]         alu_flags;

    // Nearest producer first, then WB, then the register file value
    function automatic logic [word_w-1:0] fwd(input logic [reg_addr_w-1:0] src,
                                              input logic [word_w-1:0] rf_val);
        if (exmem.wr_reg && exmem.wb_reg == src)
            return exmem.alu_rslt;
        else if (wb_wr && wb_addr == src)
            return wb_data;
        else
            return rf_val;
    endfunction

    always_comb
    begin
        fwd_a = fwd(idex.rs, idex.rs_val);
        op_b  = fwd(idex.rt, idex.rt_val);
    end

    assign op_a    = idex.imm_src ? idex.imm_se : fwd_a;
    assign shamt   = idex.imm_se[10:6];
    assign alu_sel = idex.imm_src ? alu_pass : idex.imm_se[fn_alu_lsb+:3];
    assign is_sub  = !idex.shift_op && alu_sel == alu_sub;

    // Subtract as a + ~b + 1
    assign {cout, sum} = {1'b0, op_a} + {1'b0, is_sub ? ~op_b : op_b}
                       + {{word_w{1'b0}}, is_sub};

    always_comb
    begin
        rslt  = op_a;
        carry = 1'b0;
        if (idex.shift_op)
        begin
            case (alu_sel)
                alu_sll: rslt = op_a << shamt;
                alu_srl: rslt = op_a >> shamt;
                alu_sra: rslt = $signed(op_a) >>> shamt; // Sign fill
                default: rslt = op_a;                    // alu_pass
            endcase
        end
        else
        begin
            case (alu_sel)
                alu_and: rslt = op_a & op_b;
                alu_or:  rslt = op_a | op_b;
                alu_xor: rslt = op_a ^ op_b;
                alu_add, alu_sub:
                begin
                    rslt  = sum;
                    carry = cout;
                end
                default: rslt = '0; // Unused encodings
            endcase
        end
    end

    always_comb
    begin
        alu_flags[cc_z] = rslt == '0;
        alu_flags[cc_c] = carry;
        alu_flags[cc_n] = rslt[word_w-1];
        flag_en[cc_z]   = idex.wr_z;
        flag_en[cc_c]   = idex.wr_c;
        flag_en[cc_n]   = idex.wr_n;
    end

    // Decode sees flags as they will be after this instruction
    assign flags_fwd = (flag_en & alu_flags) | (~flag_en & flag_q);

    always_ff @(posedge clk)
    begin
        if (rst)
            flag_q <= '0;
        else
            flag_q <= flags_fwd; // Disabled bits keep their value
    end

    always_ff @(posedge clk)
    begin
        exmem.alu_rslt <= rslt;
        exmem.st_data  <= op_b; // Store data is forwarded rt
        exmem.wb_reg   <= idex.rd;
        if (rst)
        begin
            exmem.mem_rd <= 1'b0;
            exmem.mem_wr <= 1'b0;
            exmem.wr_reg <= 1'b0;
        end
        else
        begin
            exmem.mem_rd <= idex.mem_rd;
            exmem.mem_wr <= idex.mem_wr;
            exmem.wr_reg <= idex.wr_reg;
        end
    end

    a_ld_st_excl: assert property (@(posedge clk) disable iff (rst)
        !(idex.mem_rd && idex.mem_wr));

endmodule

//--- hw/zmips_regfile.sv
// zmips register file, 32 words, two read ports and a write-first bypass
module zmips_regfile (
    input  logic                             clk,
    input  logic [zmips_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [zmips_pkg::reg_addr_w-1:0] rt_addr,
    input  logic [zmips_pkg::reg_addr_w-1:0] wb_addr,
    input  logic [zmips_pkg::word_w-1:0]     wb_data,
    input  logic                             wb_wr,
    output logic [zmips_pkg::word_w-1:0]     rs_val,
    output logic [zmips_pkg::word_w-1:0]     rt_val
);
    import zmips_pkg::*;

    logic [word_w-1:0] regs [2**reg_addr_w]; // r0 is an ordinary register

    always_ff @(posedge clk)
    begin
        if (wb_wr)
            regs[wb_addr] <= wb_data;
    end

    // Same-cycle write is visible to decode
    assign rs_val = (wb_wr && wb_addr == rs_addr) ? wb_data : regs[rs_addr];
    assign rt_val = (wb_wr && wb_addr == rt_addr) ? wb_data : regs[rt_addr];

endmodule

//--- hw/zmips_decode.sv
// zmips decode stage, branch resolution, load-use hazard and ID/EX register
module zmips_decode (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [zmips_pkg::word_w-1:0]     ifid_pc,
    input  zmips_pkg::instr_t                ifid_ir,
    input  logic [2:0]                       flags_fwd,
    input  logic [zmips_pkg::word_w-1:0]     rs_val,
    input  logic [zmips_pkg::word_w-1:0]     rt_val,
    output logic [zmips_pkg::reg_addr_w-1:0] rs_addr,
    output logic [zmips_pkg::reg_addr_w-1:0] rt_addr,
    output logic                             stall,
    output logic                             squash,
    output logic                             pc_load,
    output logic [zmips_pkg::word_w-1:0]     pc_target,
    id_ex_if.dec                             idex,
    ex_mem_if.fwd                            exmem
);
    import zmips_pkg::*;

    logic              is_r;
    logic              is_li;
    logic              is_br;
    logic              take;    // Branch condition met
    logic              ld_hit;  // Load in EX targets one of our sources
    logic [5:0]        op;
    logic [5:0]        funct;
    logic [word_w-1:0] imm_se;

    assign op    = ifid_ir.r.op;
    assign funct = ifid_ir.r.funct;
    assign is_r  = ifid_ir.i.fmt == fmt_r;
    assign is_li = ifid_ir.i.fmt == fmt_li;
    assign is_br = ifid_ir.i.fmt == fmt_br;

    assign rs_addr = ifid_ir.r.rs; // Regfile read is combinational
    assign rt_addr = ifid_ir.r.rt;

    assign imm_se = {{(word_w - imm_w){ifid_ir.i.imm[imm_w-1]}}, ifid_ir.i.imm};

    // Flags already include the effect of the instruction in EX
    always_comb
    begin
        case (ifid_ir.i.cc)
            cc_z:    take = flags_fwd[cc_z] == ifid_ir.i.sense;
            cc_c:    take = flags_fwd[cc_c] == ifid_ir.i.sense;
            cc_n:    take = flags_fwd[cc_n] == ifid_ir.i.sense;
            default: take = 1'b1; // cc_always
        endcase
    end

    assign pc_load   = is_br && take;
    assign pc_target = ifid_pc + pc_step + {imm_se[word_w-3:0], 2'b00};
    assign squash    = is_br || ifid_ir.i.fmt == fmt_rsvd; // Fetched word is dropped

    // Load-use, one cycle then MEM/WB forwarding takes over
    assign ld_hit = idex.mem_rd && (idex.rd == rs_addr || idex.rd == rt_addr);
    assign stall  = is_r && ld_hit;

    always_ff @(posedge clk)
    begin
        idex.rs_val <= rs_val;
        idex.rt_val <= rt_val;
        idex.rs     <= rs_addr;
        idex.rt     <= rt_addr;
        idex.rd     <= is_li ? '0 : ifid_ir.r.rd; // Load immediate always targets r0
        idex.imm_se <= imm_se;
        if (rst || stall || !(is_r || is_li)) // Bubble for hazards, branches and reserved
        begin
            idex.shift_op <= 1'b0;
            idex.imm_src  <= 1'b0;
            idex.mem_rd   <= 1'b0;
            idex.mem_wr   <= 1'b0;
            idex.wr_reg   <= 1'b0;
            idex.wr_z     <= 1'b0;
            idex.wr_c     <= 1'b0;
            idex.wr_n     <= 1'b0;
        end
        else
        begin
            idex.shift_op <= is_li || op[op_shift_bit]; // Immediate goes through pass
            idex.imm_src  <= is_li;
            idex.mem_rd   <= is_r && op[op_mem_bit] && op[op_wb_bit];
            idex.mem_wr   <= is_r && op[op_mem_bit] && !op[op_wb_bit];
            idex.wr_reg   <= is_li || op[op_wb_bit];
            idex.wr_z     <= is_r && funct[fn_z_bit];
            idex.wr_c     <= is_r && funct[fn_c_bit];
            idex.wr_n     <= is_r && funct[fn_n_bit];
        end
    end

    // The stalled instruction waits in IF/ID for its second decode
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(ifid_ir) && $stable(ifid_pc));

    // The stalling load moves on into MEM behind a bubble
    a_stall_drain: assert property (@(posedge clk) disable iff (rst)
        stall |=> exmem.mem_rd && exmem.wb_reg == $past(idex.rd) && !idex.wr_reg);

endmodule

//--- hw/zmips_fetch.sv
// zmips fetch stage, program counter and IF/ID register
module zmips_fetch #(
    parameter logic [zmips_pkg::word_w-1:0] reset_pc = '0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall,
    input  logic                         squash,
    input  logic                         pc_load,
    input  logic [zmips_pkg::word_w-1:0] pc_target,
    input  zmips_pkg::instr_t            i_data,
    output logic [zmips_pkg::word_w-1:0] pc,
    output logic [zmips_pkg::word_w-1:0] ifid_pc,
    output zmips_pkg::instr_t            ifid_ir
);
    import zmips_pkg::*;

    logic [word_w-1:0] pc_next;

    // Branch target from decode wins over sequential fetch
    assign pc_next = pc_load ? pc_target : pc + pc_step;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc      <= reset_pc;
            ifid_ir <= '0; // All-zero word is a nop
        end
        else if (!stall)
        begin
            pc      <= pc_next;
            ifid_ir <= squash ? instr_t'('0) : i_data; // Kill the slot behind a branch
        end
    end

    // Address of the instruction now in IF/ID
    always_ff @(posedge clk)
    begin
        if (!stall)
            ifid_pc <= pc;
    end

    // Only R-format stalls and only branch/reserved squashes
    a_stall_squash: assert property (@(posedge clk) disable iff (rst) !(stall && squash));

endmodule

//--- hw/zmips_pipe_if.sv
// zmips pipeline register bundles between decode, execute and memory stages
interface id_ex_if;
    import zmips_pkg::*;

    logic [word_w-1:0]     rs_val;  // Register file reads
    logic [word_w-1:0]     rt_val;
    logic [reg_addr_w-1:0] rs;      // Source numbers for forwarding
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [word_w-1:0]     imm_se;  // Low bits hold funct and shamt
    logic                  shift_op;
    logic                  imm_src; // Operand a from immediate
    logic                  mem_rd;
    logic                  mem_wr;
    logic                  wr_reg;
    logic                  wr_z;
    logic                  wr_c;
    logic                  wr_n;

    modport dec (output rs_val, rt_val, rs, rt, rd, imm_se, shift_op, imm_src,
                 mem_rd, mem_wr, wr_reg, wr_z, wr_c, wr_n);
    modport ex (input rs_val, rt_val, rs, rt, rd, imm_se, shift_op, imm_src,
                mem_rd, mem_wr, wr_reg, wr_z, wr_c, wr_n);
endinterface

interface ex_mem_if;
    import zmips_pkg::*;

    logic [word_w-1:0]     alu_rslt; // Also the data address
    logic [word_w-1:0]     st_data;
    logic [reg_addr_w-1:0] wb_reg;
    logic                  mem_rd;
    logic                  mem_wr;
    logic                  wr_reg;

    modport ex (output alu_rslt, st_data, wb_reg, mem_rd, mem_wr, wr_reg);
    modport mem (input alu_rslt, st_data, wb_reg, mem_rd, mem_wr, wr_reg);
    modport fwd (input mem_rd, wb_reg); // Load tracking seen from decode
endinterface

//--- hw/zmips_pkg.sv
// zmips shared widths, instruction field layout and opcode constants
package zmips_pkg;

    localparam int word_w     = 32; // Data, address and instruction width
    localparam int reg_addr_w = 5;  // Register number
    localparam int shamt_w    = 5;  // Shift amount
    localparam int imm_w      = 26; // Immediate / branch offset field

    // Instruction format, bits 31:30
    localparam logic [1:0] fmt_r    = 2'b00;
    localparam logic [1:0] fmt_li   = 2'b01; // Load immediate into r0
    localparam logic [1:0] fmt_br   = 2'b10;
    localparam logic [1:0] fmt_rsvd = 2'b11; // Treated as a nop

    // R-format op bit positions
    localparam int op_shift_bit = 0; // Shift group select
    localparam int op_wb_bit    = 2; // Write result to rd
    localparam int op_mem_bit   = 3; // Memory access, load when wb also set

    // Funct bit positions
    localparam int fn_z_bit   = 0;
    localparam int fn_c_bit   = 1;
    localparam int fn_n_bit   = 2;
    localparam int fn_alu_lsb = 3; // ALU operation in funct[5:3]

    // Non-shift group
    localparam logic [2:0] alu_and = 3'b000;
    localparam logic [2:0] alu_or  = 3'b001;
    localparam logic [2:0] alu_xor = 3'b010;
    localparam logic [2:0] alu_add = 3'b100;
    localparam logic [2:0] alu_sub = 3'b101;
    // Shift group
    localparam logic [2:0] alu_pass = 3'b000;
    localparam logic [2:0] alu_sll  = 3'b001;
    localparam logic [2:0] alu_srl  = 3'b010;
    localparam logic [2:0] alu_sra  = 3'b011;

    // Branch conditions, also the flag bit index
    localparam logic [1:0] cc_z      = 2'd0;
    localparam logic [1:0] cc_c      = 2'd1;
    localparam logic [1:0] cc_n      = 2'd2;
    localparam logic [1:0] cc_always = 2'd3;

    localparam logic [word_w-1:0] pc_step = 32'd4;

    typedef struct packed {
        logic [5:0]            op;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        logic [shamt_w-1:0]    shamt;
        logic [5:0]            funct;
    } r_instr_t;

    typedef struct packed {
        logic [1:0]       fmt;
        logic             sense; // 1 branches on flag set
        logic             spare;
        logic [1:0]       cc;
        logic [imm_w-1:0] imm;
    } i_instr_t;

    // Same word seen as R-format or I-format
    typedef union packed {
        r_instr_t r;
        i_instr_t i;
    } instr_t;

endpackage
